//--- hw/exe_params.svh
// Width and iteration settings for the execute stage.
// The divider assumes EXE_DIV_STEPS equals EXE_XLEN, one quotient bit per step.
// EXE_XLEN must be at least 8 for the ALU shift-amount slice.

`ifndef EXE_PARAMS_SVH
`define EXE_PARAMS_SVH

// Data and address width
`define EXE_XLEN 32

// Register index width, 32 architectural registers
`define EXE_REG_W 5

// Restoring divider, one step per clock
`define EXE_DIV_STEPS `EXE_XLEN

`endif

//--- hw/isa_pkg.sv
// Operation codes and execution unit selectors for the execute stage.
// Encodings are internal to the core and carry no RISC-V opcode meaning.
// Decode upstream is expected to pair every instr_type with a matching unit.

`default_nettype none

package isa_pkg;

    // Operation codes, grouped by the unit that executes them
    typedef enum logic [4:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SRA,
        SLT,
        SLTU,
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU,
        JAL,
        JALR,
        DIV,
        DIVU,
        REM,
        REMU,
        LOAD,
        STORE
    } instr_type_t;

    typedef enum logic [2:0] {
        UNIT_ALU,
        UNIT_BRANCH,
        UNIT_DIV,
        UNIT_MEM,
        UNIT_NONE
    } unit_t;

endpackage

`default_nettype wire

//--- hw/pipe_pkg.sv
// Pipeline records around the execute stage and the data-cache port.
// All records are plain levels with no handshake; valid qualifies contents.
// Widths come from exe_params.svh.

`default_nettype none

`include "exe_params.svh"

package pipe_pkg;

    // Register read to execute
    typedef struct packed {
        logic                       valid;
        logic [`EXE_XLEN-1:0]       pc;
        logic [`EXE_REG_W-1:0]      rs1;
        logic [`EXE_REG_W-1:0]      rs2;
        logic [`EXE_REG_W-1:0]      rd;
        logic [`EXE_XLEN-1:0]       imm;
        logic                       use_imm;
        logic                       use_pc;
        isa_pkg::unit_t             unit;
        isa_pkg::instr_type_t       instr_type;
        logic [2:0]                 funct3;
        logic [`EXE_XLEN-1:0]       data_rs1;
        logic [`EXE_XLEN-1:0]       data_rs2;
    } rr_exe_instr_t;

    // Forwarding from write-back
    typedef struct packed {
        logic                       valid;
        logic [`EXE_REG_W-1:0]      rd;
        logic [`EXE_XLEN-1:0]       data;
    } wb_exe_instr_t;

    // Execute to write-back
    typedef struct packed {
        logic                       valid;
        logic [`EXE_XLEN-1:0]       pc;
        logic [`EXE_REG_W-1:0]      rd;
        isa_pkg::unit_t             unit;
        logic [`EXE_XLEN-1:0]       result_rd;
        logic [`EXE_XLEN-1:0]       result_pc;
        logic                       branch_taken;
    } exe_wb_instr_t;

    // Data-cache request, address is formed by the cache side from rs1 + imm
    typedef struct packed {
        logic                       valid;
        logic                       kill;
        logic [`EXE_XLEN-1:0]       data_rs1;
        logic [`EXE_XLEN-1:0]       data_rs2;
        logic [`EXE_XLEN-1:0]       imm;
        isa_pkg::instr_type_t       instr_type;
        logic [2:0]                 funct3;
        logic [`EXE_REG_W-1:0]      rd;
    } req_cpu_dcache_t;

    // Lock holds the pipeline, ready qualifies load data
    typedef struct packed {
        logic                       ready;
        logic                       lock;
        logic [`EXE_XLEN-1:0]       data;
    } resp_dcache_cpu_t;

endpackage

`default_nettype wire

//--- hw/alu.sv
// Combinational integer ALU.
// Shifts use only the low log2(XLEN) bits of operand 2.
// Codes that do not belong to the ALU give a zero result.

`timescale 1ns/10ps
`default_nettype none

`include "exe_params.svh"

module alu (
    input  logic [`EXE_XLEN-1:0]    data_rs1_i,
    input  logic [`EXE_XLEN-1:0]    data_rs2_i,
    input  isa_pkg::instr_type_t    instr_type_i,
    output logic [`EXE_XLEN-1:0]    result_o
);

    localparam int SHAMT_W = $clog2(`EXE_XLEN);

    logic [SHAMT_W-1:0] shamt;
    logic               lt_signed;
    logic               lt_unsigned;

    assign shamt       = data_rs2_i[SHAMT_W-1:0];
    assign lt_signed   = $signed(data_rs1_i) < $signed(data_rs2_i);
    assign lt_unsigned = data_rs1_i < data_rs2_i;

    always_comb begin
        case (instr_type_i)
            isa_pkg::ADD:  result_o = data_rs1_i + data_rs2_i;
            isa_pkg::SUB:  result_o = data_rs1_i - data_rs2_i;
            isa_pkg::AND:  result_o = data_rs1_i & data_rs2_i;
            isa_pkg::OR:   result_o = data_rs1_i | data_rs2_i;
            isa_pkg::XOR:  result_o = data_rs1_i ^ data_rs2_i;
            isa_pkg::SLL:  result_o = data_rs1_i << shamt;
            isa_pkg::SRL:  result_o = data_rs1_i >> shamt;
            // Arithmetic shift keeps the sign bit
            isa_pkg::SRA:  result_o = $unsigned($signed(data_rs1_i) >>> shamt);
            isa_pkg::SLT: begin
                result_o = {{(`EXE_XLEN-1){1'b0}}, lt_signed};
            end
            isa_pkg::SLTU: begin
                result_o = {{(`EXE_XLEN-1){1'b0}}, lt_unsigned};
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hw/branch_unit.sv
// Branch condition, target and link address, all combinational.
// JAL and JALR are always taken; the JALR target has bit 0 cleared.
// Non-branch codes report not taken and fall through to pc + 4.

`timescale 1ns/10ps
`default_nettype none

`include "exe_params.svh"

module branch_unit (
    input  isa_pkg::instr_type_t    instr_type_i,
    input  logic [`EXE_XLEN-1:0]    pc_i,
    input  logic [`EXE_XLEN-1:0]    data_rs1_i,
    input  logic [`EXE_XLEN-1:0]    data_rs2_i,
    input  logic [`EXE_XLEN-1:0]    imm_i,
    output logic                    taken_o,
    output logic [`EXE_XLEN-1:0]    target_o,
    output logic [`EXE_XLEN-1:0]    result_o,
    output logic [`EXE_XLEN-1:0]    reg_data_o
);

    logic [`EXE_XLEN-1:0] link_addr;
    logic [`EXE_XLEN-1:0] jalr_sum;

    assign link_addr = pc_i + `EXE_XLEN'd4;
    assign jalr_sum  = data_rs1_i + imm_i;

    always_comb begin
        case (instr_type_i)
            isa_pkg::BEQ:  taken_o = data_rs1_i == data_rs2_i;
            isa_pkg::BNE:  taken_o = data_rs1_i != data_rs2_i;
            isa_pkg::BLT:  taken_o = $signed(data_rs1_i) < $signed(data_rs2_i);
            isa_pkg::BGE:  taken_o = $signed(data_rs1_i) >= $signed(data_rs2_i);
            isa_pkg::BLTU: taken_o = data_rs1_i < data_rs2_i;
            isa_pkg::BGEU: taken_o = data_rs1_i >= data_rs2_i;
            isa_pkg::JAL,
            isa_pkg::JALR: taken_o = 1'b1;
            default:       taken_o = 1'b0;
        endcase
    end

    // Register-relative jump versus PC-relative branch
    assign target_o = (instr_type_i == isa_pkg::JALR) ?
                      {jalr_sum[`EXE_XLEN-1:1], 1'b0} : pc_i + imm_i;

    assign result_o   = taken_o ? target_o : link_addr;
    assign reg_data_o = link_addr;

endmodule

`default_nettype wire

//--- hw/div_unit.sv
// Iterative restoring divider, one quotient bit per clock.
// Latency is EXE_DIV_STEPS + 1 edges from start to done_tick_o.
// Operands are sampled once at start; they may change afterwards.
// Divide by zero gives all ones and the dividend as remainder.
// Results are only meaningful while done_tick_o is high.

`timescale 1ns/10ps
`default_nettype none

`include "exe_params.svh"

module div_unit (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    kill_div_i,
    input  logic                    request_i,
    input  logic                    signed_op_i,
    input  logic [`EXE_XLEN-1:0]    dvnd_i,
    input  logic [`EXE_XLEN-1:0]    dvsr_i,
    output logic [`EXE_XLEN-1:0]    quo_o,
    output logic [`EXE_XLEN-1:0]    rmd_o,
    output logic                    stall_o,
    output logic                    done_tick_o
);

    localparam int CNT_W = $clog2(`EXE_DIV_STEPS);

    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        DONE
    } div_state_t;

    div_state_t             state_q;
    logic [CNT_W-1:0]       cnt_q;
    logic [`EXE_XLEN-1:0]   quo_q;
    logic [`EXE_XLEN-1:0]   rem_q;
    logic [`EXE_XLEN-1:0]   dvsr_q;
    logic                   neg_quo_q;
    logic                   neg_rmd_q;
    logic                   dvnd_neg;
    logic                   dvsr_neg;
    logic [`EXE_XLEN-1:0]   dvnd_abs;
    logic [`EXE_XLEN-1:0]   dvsr_abs;
    logic [`EXE_XLEN:0]     shifted;
    logic [`EXE_XLEN:0]     diff;
    logic                   start;

    // Magnitudes for the unsigned core
    assign dvnd_neg = signed_op_i & dvnd_i[`EXE_XLEN-1];
    assign dvsr_neg = signed_op_i & dvsr_i[`EXE_XLEN-1];
    assign dvnd_abs = dvnd_neg ? -dvnd_i : dvnd_i;
    assign dvsr_abs = dvsr_neg ? -dvsr_i : dvsr_i;

    assign start   = (state_q == IDLE) & request_i & ~kill_div_i;
    assign shifted = {rem_q, quo_q[`EXE_XLEN-1]};
    assign diff    = shifted - {1'b0, dvsr_q};

    // ------------------------------------------------------------------
    // Control
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else if (kill_div_i) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start) begin
                        state_q <= BUSY;
                        cnt_q   <= CNT_W'(`EXE_DIV_STEPS - 1);
                    end
                end
                BUSY: begin
                    if (cnt_q == '0) begin
                        state_q <= DONE;
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // ------------------------------------------------------------------
    // Datapath
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (start) begin
            quo_q     <= dvnd_abs;
            rem_q     <= '0;
            dvsr_q    <= dvsr_abs;
            // Zero divisor keeps the all-ones quotient unsigned
            neg_quo_q <= (dvnd_neg ^ dvsr_neg) & (dvsr_i != '0);
            neg_rmd_q <= dvnd_neg;
        end else if (state_q == BUSY) begin
            if (!diff[`EXE_XLEN]) begin
                rem_q <= diff[`EXE_XLEN-1:0];
                quo_q <= {quo_q[`EXE_XLEN-2:0], 1'b1};
            end else begin
                rem_q <= shifted[`EXE_XLEN-1:0];
                quo_q <= {quo_q[`EXE_XLEN-2:0], 1'b0};
            end
        end
    end

    // Overflow case falls out naturally: magnitude 2^(XLEN-1), positive sign
    assign quo_o = neg_quo_q ? -quo_q : quo_q;
    assign rmd_o = neg_rmd_q ? -rem_q : rem_q;

    assign stall_o     = start | (state_q == BUSY);
    assign done_tick_o = state_q == DONE;

endmodule

`default_nettype wire

//--- hw/exe_top.sv
// Execute stage: write-back bypass, operand selection, unit dispatch,
// data-cache request and write-back result selection.
// ALU, branch and memory results appear in the same cycle as the input.
// The upstream stage must hold from_rr_i stable while stall_o is high.
// Divider results are driven only in the done_tick cycle, else zero.

`timescale 1ns/10ps
`default_nettype none

`include "exe_params.svh"

module exe_top (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        kill_i,
    input  pipe_pkg::rr_exe_instr_t     from_rr_i,
    input  pipe_pkg::wb_exe_instr_t     from_wb_i,
    input  pipe_pkg::resp_dcache_cpu_t  resp_dcache_cpu_i,
    output pipe_pkg::exe_wb_instr_t     to_wb_o,
    output logic                        stall_o,
    output pipe_pkg::req_cpu_dcache_t   req_cpu_dcache_o
);

    logic [`EXE_XLEN-1:0]   rs1_bypass;
    logic [`EXE_XLEN-1:0]   rs2_bypass;
    logic [`EXE_XLEN-1:0]   op1_sel;
    logic [`EXE_XLEN-1:0]   op2_sel;
    logic [`EXE_XLEN-1:0]   result_alu;
    logic [`EXE_XLEN-1:0]   result_quo;
    logic [`EXE_XLEN-1:0]   result_rmd;
    logic [`EXE_XLEN-1:0]   result_branch;
    logic [`EXE_XLEN-1:0]   link_branch;
    logic [`EXE_XLEN-1:0]   result_mem;
    logic                   taken_branch;
    logic                   stall_div;
    logic                   done_div;
    logic                   is_div;
    logic                   is_mem;
    logic                   div_signed;

    // ------------------------------------------------------------------
    // Bypass and operand selection
    // ------------------------------------------------------------------
    // x0 never takes a forwarded value
    assign rs1_bypass = ((from_rr_i.rs1 != '0) && (from_rr_i.rs1 == from_wb_i.rd)
                         && from_wb_i.valid) ? from_wb_i.data : from_rr_i.data_rs1;
    assign rs2_bypass = ((from_rr_i.rs2 != '0) && (from_rr_i.rs2 == from_wb_i.rd)
                         && from_wb_i.valid) ? from_wb_i.data : from_rr_i.data_rs2;

    assign op1_sel = from_rr_i.use_pc  ? from_rr_i.pc  : rs1_bypass;
    assign op2_sel = from_rr_i.use_imm ? from_rr_i.imm : rs2_bypass;

    assign is_div     = from_rr_i.valid & (from_rr_i.unit == isa_pkg::UNIT_DIV);
    assign is_mem     = from_rr_i.valid & (from_rr_i.unit == isa_pkg::UNIT_MEM);
    assign div_signed = (from_rr_i.instr_type == isa_pkg::DIV) |
                        (from_rr_i.instr_type == isa_pkg::REM);

    alu i_alu (
        .data_rs1_i   (op1_sel),
        .data_rs2_i   (op2_sel),
        .instr_type_i (from_rr_i.instr_type),
        .result_o     (result_alu)
    );

    branch_unit i_branch_unit (
        .instr_type_i (from_rr_i.instr_type),
        .pc_i         (from_rr_i.pc),
        .data_rs1_i   (rs1_bypass),
        .data_rs2_i   (rs2_bypass),
        .imm_i        (from_rr_i.imm),
        .taken_o      (taken_branch),
        .target_o     (),
        .result_o     (result_branch),
        .reg_data_o   (link_branch)
    );

    div_unit i_div_unit (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .kill_div_i   (kill_i),
        .request_i    (is_div),
        .signed_op_i  (div_signed),
        .dvnd_i       (rs1_bypass),
        .dvsr_i       (op2_sel),
        .quo_o        (result_quo),
        .rmd_o        (result_rmd),
        .stall_o      (stall_div),
        .done_tick_o  (done_div)
    );

    // ------------------------------------------------------------------
    // Data-cache port
    // ------------------------------------------------------------------
    assign req_cpu_dcache_o.valid      = is_mem;
    assign req_cpu_dcache_o.kill       = kill_i;
    assign req_cpu_dcache_o.data_rs1   = rs1_bypass;
    assign req_cpu_dcache_o.data_rs2   = rs2_bypass;
    assign req_cpu_dcache_o.imm        = from_rr_i.imm;
    assign req_cpu_dcache_o.instr_type = from_rr_i.instr_type;
    assign req_cpu_dcache_o.funct3     = from_rr_i.funct3;
    assign req_cpu_dcache_o.rd         = from_rr_i.rd;

    assign result_mem = resp_dcache_cpu_i.ready ? resp_dcache_cpu_i.data : '0;

    // ------------------------------------------------------------------
    // Write-back record and stall
    // ------------------------------------------------------------------
    always_comb begin
        to_wb_o.valid        = from_rr_i.valid;
        to_wb_o.pc           = from_rr_i.pc;
        to_wb_o.rd           = from_rr_i.rd;
        to_wb_o.unit         = from_rr_i.unit;
        to_wb_o.result_rd    = '0;
        to_wb_o.result_pc    = '0;
        to_wb_o.branch_taken = 1'b0;
        case (from_rr_i.unit)
            isa_pkg::UNIT_ALU: to_wb_o.result_rd = result_alu;
            isa_pkg::UNIT_DIV: begin
                if (done_div) begin
                    to_wb_o.result_rd = ((from_rr_i.instr_type == isa_pkg::REM) ||
                                         (from_rr_i.instr_type == isa_pkg::REMU)) ?
                                        result_rmd : result_quo;
                end
            end
            isa_pkg::UNIT_BRANCH: begin
                to_wb_o.result_rd    = link_branch;
                to_wb_o.result_pc    = result_branch;
                to_wb_o.branch_taken = taken_branch;
            end
            isa_pkg::UNIT_MEM: to_wb_o.result_rd = result_mem;
            default: begin
                to_wb_o.result_rd = '0;
            end
        endcase
    end

    assign stall_o = is_div ? stall_div :
                     is_mem ? resp_dcache_cpu_i.lock :
                     1'b0;

endmodule

`default_nettype wire

//--- verification/tb_exe_top.sv
// Self-checking testbench for the execute stage.
// The testbench plays register read, write-back forwarding and the data cache.
// Table rows use pc 0x1000, rd x7, and read rs1 = x1 and rs2 = x2 unless changed.
// Branch rows use an offset of 0x40. Every row is held until stall_o falls.

`timescale 1ns/10ps
`default_nettype none

`include "exe_params.svh"

module tb_exe_top;

    localparam logic [`EXE_XLEN-1:0] PC      = 32'h0000_1000;
    localparam logic [`EXE_XLEN-1:0] BR_OFFS = 32'h0000_0040;
    localparam int                   TIMEOUT = 100;

    typedef struct packed {
        pipe_pkg::rr_exe_instr_t    instr;
        pipe_pkg::wb_exe_instr_t    wb;
        pipe_pkg::resp_dcache_cpu_t resp;
        int                         lock_cycles;
        logic [`EXE_XLEN-1:0]       exp_rd;
        logic [`EXE_XLEN-1:0]       exp_pc;
        logic                       exp_taken;
        logic                       exp_req;
    } row_t;

    logic                           clk_i = 1'b0;
    logic                           rst_n_i;
    logic                           kill_i;
    pipe_pkg::rr_exe_instr_t        from_rr_i;
    pipe_pkg::wb_exe_instr_t        from_wb_i;
    pipe_pkg::resp_dcache_cpu_t     resp_i;
    pipe_pkg::exe_wb_instr_t        to_wb_o;
    logic                           stall_o;
    pipe_pkg::req_cpu_dcache_t      req_o;

    row_t   rows[$];
    int     kill_idx;
    int     checks = 0;
    int     errors = 0;
    logic   timed_out = 1'b0;
    integer seed;

    always #2 clk_i = ~clk_i;

    exe_top i_exe_top (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .kill_i            (kill_i),
        .from_rr_i         (from_rr_i),
        .from_wb_i         (from_wb_i),
        .resp_dcache_cpu_i (resp_i),
        .to_wb_o           (to_wb_o),
        .stall_o           (stall_o),
        .req_cpu_dcache_o  (req_o)
    );

    // ------------------------------------------------------------------
    // Checking
    // ------------------------------------------------------------------
    task automatic check_val(input string name, input logic [`EXE_XLEN-1:0] exp,
                             input logic [`EXE_XLEN-1:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("ERR %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("ERR %s: expected %h, got %h", name, exp, act);
        end
    endtask

    // Reference ALU built from the operation definitions
    function automatic logic [`EXE_XLEN-1:0] alu_expect(input isa_pkg::instr_type_t op,
            input logic [`EXE_XLEN-1:0] a, input logic [`EXE_XLEN-1:0] b);
        logic [4:0] s;
        s = b[4:0];
        case (op)
            isa_pkg::ADD:  return a + b;
            isa_pkg::SUB:  return a + ~b + 32'd1;
            isa_pkg::AND:  return a & b;
            isa_pkg::OR:   return a | b;
            isa_pkg::XOR:  return a ^ b;
            isa_pkg::SLL:  return a << s;
            isa_pkg::SRL:  return a >> s;
            isa_pkg::SRA:  return (a >> s) | (a[31] ? ~(32'hffff_ffff >> s) : 32'h0);
            isa_pkg::SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            isa_pkg::SLTU: return (a < b) ? 32'd1 : 32'd0;
            default:       return 32'd0;
        endcase
    endfunction

    // ------------------------------------------------------------------
    // Table construction
    // ------------------------------------------------------------------
    function automatic pipe_pkg::rr_exe_instr_t build_instr(input isa_pkg::unit_t u,
            input isa_pkg::instr_type_t op, input logic [`EXE_XLEN-1:0] d1,
            input logic [`EXE_XLEN-1:0] d2, input logic [`EXE_XLEN-1:0] imm,
            input logic [1:0] pc_imm);
        pipe_pkg::rr_exe_instr_t ins;
        ins            = '0;
        ins.valid      = 1'b1;
        ins.pc         = PC;
        ins.rs1        = 5'd1;
        ins.rs2        = 5'd2;
        ins.rd         = 5'd7;
        ins.imm        = imm;
        ins.use_pc     = pc_imm[1];
        ins.use_imm    = pc_imm[0];
        ins.unit       = u;
        ins.instr_type = op;
        ins.funct3     = 3'b010;
        ins.data_rs1   = d1;
        ins.data_rs2   = d2;
        return ins;
    endfunction

    function automatic pipe_pkg::wb_exe_instr_t make_fwd(input logic v, input logic [4:0] rd,
            input logic [`EXE_XLEN-1:0] data);
        pipe_pkg::wb_exe_instr_t wb;
        wb.valid = v;
        wb.rd    = rd;
        wb.data  = data;
        return wb;
    endfunction

    function automatic void add_row(input pipe_pkg::rr_exe_instr_t ins,
            input pipe_pkg::wb_exe_instr_t wb, input int lock,
            input logic [`EXE_XLEN-1:0] rdata, input logic [`EXE_XLEN-1:0] exp_rd,
            input logic [`EXE_XLEN-1:0] exp_pc, input logic exp_taken, input logic exp_req);
        row_t r;
        r.instr       = ins;
        r.wb          = wb;
        r.resp.ready  = 1'b1;
        r.resp.lock   = lock != 0;
        r.resp.data   = rdata;
        r.lock_cycles = lock;
        r.exp_rd      = exp_rd;
        r.exp_pc      = exp_pc;
        r.exp_taken   = exp_taken;
        r.exp_req     = exp_req;
        rows.push_back(r);
    endfunction

    function automatic void alu_row(input isa_pkg::instr_type_t op,
            input logic [`EXE_XLEN-1:0] d1, input logic [`EXE_XLEN-1:0] d2,
            input logic [`EXE_XLEN-1:0] imm, input logic [1:0] pc_imm,
            input logic [`EXE_XLEN-1:0] exp);
        add_row(build_instr(isa_pkg::UNIT_ALU, op, d1, d2, imm, pc_imm), '0, 0, 32'h0,
                exp, 32'h0, 1'b0, 1'b0);
    endfunction

    // Link value is always pc + 4
    function automatic void branch_row(input isa_pkg::instr_type_t op,
            input logic [`EXE_XLEN-1:0] d1, input logic [`EXE_XLEN-1:0] d2,
            input logic taken, input logic [`EXE_XLEN-1:0] exp_pc);
        add_row(build_instr(isa_pkg::UNIT_BRANCH, op, d1, d2, BR_OFFS, 2'b00), '0, 0,
                32'h0, PC + 32'd4, exp_pc, taken, 1'b0);
    endfunction

    function automatic void div_row(input isa_pkg::instr_type_t op,
            input logic [`EXE_XLEN-1:0] d1, input logic [`EXE_XLEN-1:0] d2,
            input logic [`EXE_XLEN-1:0] exp);
        add_row(build_instr(isa_pkg::UNIT_DIV, op, d1, d2, 32'h0, 2'b00), '0, 0, 32'h0,
                exp, 32'h0, 1'b0, 1'b0);
    endfunction

    // Load data is returned as the write-back value
    function automatic void mem_row(input isa_pkg::instr_type_t op,
            input logic [`EXE_XLEN-1:0] d1, input logic [`EXE_XLEN-1:0] d2,
            input logic [`EXE_XLEN-1:0] imm, input int lock,
            input logic [`EXE_XLEN-1:0] rdata);
        add_row(build_instr(isa_pkg::UNIT_MEM, op, d1, d2, imm, 2'b00), '0, lock, rdata,
                rdata, 32'h0, 1'b0, 1'b1);
    endfunction

    task automatic build_table();
        pipe_pkg::rr_exe_instr_t ins;
        isa_pkg::instr_type_t    op;
        logic [`EXE_XLEN-1:0]    a;
        logic [`EXE_XLEN-1:0]    b;
        int                      sel;
        alu_row(isa_pkg::ADD,  32'h10, 32'h20, 32'h0, 2'b00, 32'h30);
        alu_row(isa_pkg::SUB,  32'h10, 32'h20, 32'h0, 2'b00, 32'hffff_fff0);
        alu_row(isa_pkg::SLT,  32'hffff_ffff, 32'h1, 32'h0, 2'b00, 32'h1);
        alu_row(isa_pkg::SLTU, 32'hffff_ffff, 32'h1, 32'h0, 2'b00, 32'h0);
        alu_row(isa_pkg::SRA,  32'h8000_0000, 32'h4, 32'h0, 2'b00, 32'hf800_0000);
        alu_row(isa_pkg::SRL,  32'h8000_0000, 32'h4, 32'h0, 2'b00, 32'h0800_0000);
        alu_row(isa_pkg::SLL,  32'h1, 32'h24, 32'h0, 2'b00, 32'h10);
        alu_row(isa_pkg::XOR,  32'hff00_ff00, 32'h0, 32'h0f0f_0f0f, 2'b01, 32'hf00f_f00f);
        alu_row(isa_pkg::ADD,  32'h5, 32'h6, 32'h20, 2'b11, 32'h1020);
        // Forwarding, then x0 and a stale record
        ins = build_instr(isa_pkg::UNIT_ALU, isa_pkg::ADD, 32'h1, 32'h2, 32'h0, 2'b00);
        add_row(ins, make_fwd(1'b1, 5'd1, 32'h100), 0, 32'h0, 32'h102, 32'h0, 1'b0, 1'b0);
        add_row(ins, make_fwd(1'b1, 5'd2, 32'h200), 0, 32'h0, 32'h201, 32'h0, 1'b0, 1'b0);
        add_row(ins, make_fwd(1'b0, 5'd1, 32'h100), 0, 32'h0, 32'h3, 32'h0, 1'b0, 1'b0);
        ins.rs1 = 5'd0;
        add_row(ins, make_fwd(1'b1, 5'd0, 32'h55), 0, 32'h0, 32'h3, 32'h0, 1'b0, 1'b0);
        branch_row(isa_pkg::BEQ,  32'h5, 32'h5, 1'b1, 32'h1040);
        branch_row(isa_pkg::BNE,  32'h5, 32'h5, 1'b0, 32'h1004);
        branch_row(isa_pkg::BLT,  32'hffff_ffff, 32'h1, 1'b1, 32'h1040);
        branch_row(isa_pkg::BLTU, 32'hffff_ffff, 32'h1, 1'b0, 32'h1004);
        branch_row(isa_pkg::BGE,  32'h1, 32'hffff_ffff, 1'b1, 32'h1040);
        branch_row(isa_pkg::BGEU, 32'h1, 32'hffff_ffff, 1'b0, 32'h1004);
        branch_row(isa_pkg::JAL,  32'h0, 32'h0, 1'b1, 32'h1040);
        branch_row(isa_pkg::JALR, 32'h2001, 32'h0, 1'b1, 32'h2040);
        div_row(isa_pkg::DIV,  32'hffff_fff9, 32'h2, 32'hffff_fffd);
        div_row(isa_pkg::REM,  32'hffff_fff9, 32'h2, 32'hffff_ffff);
        div_row(isa_pkg::DIVU, 32'hffff_fff9, 32'h2, 32'h7fff_fffc);
        div_row(isa_pkg::REMU, 32'hffff_fff9, 32'h2, 32'h1);
        div_row(isa_pkg::DIV,  32'h7, 32'hffff_fffe, 32'hffff_fffd);
        div_row(isa_pkg::REM,  32'h7, 32'hffff_fffe, 32'h1);
        div_row(isa_pkg::DIV,  32'h1234, 32'h0, 32'hffff_ffff);
        div_row(isa_pkg::REMU, 32'h1234, 32'h0, 32'h1234);
        div_row(isa_pkg::DIV,  32'h8000_0000, 32'hffff_ffff, 32'h8000_0000);
        div_row(isa_pkg::REM,  32'h8000_0000, 32'hffff_ffff, 32'h0);
        mem_row(isa_pkg::LOAD,  32'h3000, 32'h0, 32'h8, 3, 32'hcafe_babe);
        mem_row(isa_pkg::STORE, 32'h3004, 32'hdead_beef, 32'h4, 0, 32'h0);
        // Division right after an aborted one
        kill_idx = rows.size();
        div_row(isa_pkg::DIVU, 32'd1000, 32'd7, 32'd142);
        for (int k = 0; k < 12; k++) begin
            sel = $unsigned($random(seed)) % 10;
            op  = isa_pkg::instr_type_t'(sel[4:0]);
            a   = $random(seed);
            b   = $random(seed);
            alu_row(op, a, b, 32'h0, 2'b00, alu_expect(op, a, b));
        end
    endtask

    // ------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------
    task automatic apply_row(input row_t r);
        int   cycles;
        int   edges;
        logic exp_stall;
        cycles    = 0;
        edges     = 0;
        exp_stall = (r.instr.unit == isa_pkg::UNIT_DIV) || (r.lock_cycles != 0);
        @(posedge clk_i);
        from_rr_i <= r.instr;
        from_wb_i <= r.wb;
        resp_i    <= r.resp;
        @(negedge clk_i);
        check_bit("stall_o", exp_stall, stall_o);
        // Lock is released after the programmed number of edges
        while (stall_o && !timed_out) begin
            if (cycles == TIMEOUT) begin
                $display("Timeout: stall_o stayed high for %0d cycles", TIMEOUT);
                errors++;
                timed_out = 1'b1;
            end else begin
                @(posedge clk_i);
                edges++;
                if (edges == r.lock_cycles) begin
                    resp_i.lock <= 1'b0;
                end
                @(negedge clk_i);
                cycles++;
                if (r.lock_cycles != 0) begin
                    check_bit("stall_o", edges < r.lock_cycles, stall_o);
                end
            end
        end
        check_val("to_wb_o.result_rd", r.exp_rd, to_wb_o.result_rd);
        check_val("to_wb_o.result_pc", r.exp_pc, to_wb_o.result_pc);
        check_bit("to_wb_o.branch_taken", r.exp_taken, to_wb_o.branch_taken);
        check_bit("to_wb_o.valid", r.instr.valid, to_wb_o.valid);
        check_val("to_wb_o.pc", r.instr.pc, to_wb_o.pc);
        check_val("to_wb_o.rd", 32'(r.instr.rd), 32'(to_wb_o.rd));
        check_val("to_wb_o.unit", 32'(r.instr.unit), 32'(to_wb_o.unit));
        check_bit("req_cpu_dcache_o.valid", r.exp_req, req_o.valid);
        check_bit("req_cpu_dcache_o.kill", 1'b0, req_o.kill);
        if (r.exp_req) begin
            check_val("req_cpu_dcache_o.data_rs1", r.instr.data_rs1, req_o.data_rs1);
            check_val("req_cpu_dcache_o.data_rs2", r.instr.data_rs2, req_o.data_rs2);
            check_val("req_cpu_dcache_o.imm", r.instr.imm, req_o.imm);
            check_val("req_cpu_dcache_o.instr_type", 32'(r.instr.instr_type),
                      32'(req_o.instr_type));
            check_val("req_cpu_dcache_o.funct3", 32'(r.instr.funct3), 32'(req_o.funct3));
            check_val("req_cpu_dcache_o.rd", 32'(r.instr.rd), 32'(req_o.rd));
        end
    endtask

    // Abort a running division; kill stays high for two cycles
    task automatic run_kill();
        @(posedge clk_i);
        from_rr_i   <= build_instr(isa_pkg::UNIT_DIV, isa_pkg::DIVU, 32'd100, 32'd7,
                                   32'h0, 2'b00);
        from_wb_i   <= '0;
        resp_i.lock <= 1'b0;
        repeat (5) @(posedge clk_i);
        kill_i <= 1'b1;
        @(negedge clk_i);
        check_bit("stall_o", 1'b1, stall_o);
        check_bit("req_cpu_dcache_o.kill", 1'b1, req_o.kill);
        @(negedge clk_i);
        check_bit("stall_o", 1'b0, stall_o);
        @(posedge clk_i);
        kill_i          <= 1'b0;
        from_rr_i.valid <= 1'b0;
    endtask

    initial begin
        seed      = 32'hf185c3a7;
        rst_n_i   = 1'b0;
        kill_i    = 1'b0;
        from_rr_i = '0;
        from_wb_i = '0;
        resp_i    = '0;
        build_table();
        repeat (4) @(posedge clk_i);
        rst_n_i <= 1'b1;
        for (int i = 0; i < rows.size() && !timed_out; i++) begin
            if (i == kill_idx) begin
                run_kill();
            end
            apply_row(rows[i]);
        end
        $display("Checks %0d, errors %0d, timeout %0d", checks, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+hw
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/alu.sv
hw/branch_unit.sv
hw/div_unit.sv
hw/exe_top.sv
verification/tb_exe_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the execute-stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f tb.f --top-module tb_exe_top -Mdir obj_dir

out=$(./obj_dir/Vtb_exe_top)
echo "$out"
if echo "$out" | grep -qx "ALL TESTS PASSED"; then
    exit 0
fi
exit 1
